// File: source/intc_pkg.sv
// Interrupt controller constants
`default_nettype none

package intc_pkg;

    // Source count and field widths
    localparam int N_SRC = 8;
    localparam int PRIO_W = 3;
    localparam int ID_W = 3;

    // Input synchronizer depth
    localparam int SYNC_STAGES = 2;

    // Register map, byte addresses on the APB bus

    // Mask, one bit per source, 1 blocks the source
    localparam logic [7:0] ADDR_MASK = 8'h00;

    // Priorities, source k in bits 3k+2..3k
    localparam logic [7:0] ADDR_PRIO = 8'h04;

    // Trigger mode, 1 for rising edge and 0 for level
    localparam logic [7:0] ADDR_MODE = 8'h08;

    // Pending bits, writing ones clears latched edges
    localparam logic [7:0] ADDR_PENDING = 8'h0C;

    // Claim word, valid in bit 8 and id in bits 2..0
    localparam logic [7:0] ADDR_CLAIM = 8'h10;

endpackage

`default_nettype wire

// File: source/intc_regs.sv
// APB register block
`timescale 1ns/1ps
`default_nettype none

module intc_regs
    import intc_pkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      resetn,

    // APB slave side, no wait states
    input  wire logic                      psel,
    input  wire logic                      penable,
    input  wire logic                      pwrite,
    input  wire logic [7:0]                paddr,
    input  wire logic [31:0]               pwdata,
    output logic      [31:0]               prdata,

    // Status coming back for readback
    input  wire logic [N_SRC-1:0]          pending,
    input  wire logic                      irq,
    input  wire logic [ID_W-1:0]           irq_id,

    // Configuration to capture and resolver
    output logic      [N_SRC-1:0]          mask,
    output logic      [N_SRC*PRIO_W-1:0]   priority_config,
    output logic      [N_SRC-1:0]          edge_mode,
    output logic      [N_SRC-1:0]          clear_pending
);

    logic        wr_en;
    logic [31:0] claim_word;

    // Writes land at the edge that closes the access phase
    assign wr_en = psel && penable && pwrite;

    // Write-one-to-clear strobe, lasts exactly the access cycle
    assign clear_pending = (wr_en && (paddr == ADDR_PENDING))
        ? pwdata[N_SRC-1:0] : '0;

    // Configuration registers
    // Everything starts masked, at priority 0 and in level mode
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            mask <= '1;
            priority_config <= '0;
            edge_mode <= '0;
        end else if (wr_en) begin
            case (paddr)
                ADDR_MASK: begin
                    mask <= pwdata[N_SRC-1:0];
                end
                ADDR_PRIO: begin
                    priority_config <= pwdata[N_SRC*PRIO_W-1:0];
                end
                ADDR_MODE: begin
                    edge_mode <= pwdata[N_SRC-1:0];
                end
                default: begin
                    // Pending is handled by the strobe, the rest is read only
                end
            endcase
        end
    end

    // Claim word from the live resolver output
    always_comb begin
        claim_word = '0;
        claim_word[8] = irq;
        claim_word[ID_W-1:0] = irq_id;
    end

    // Read multiplexer
    // Unimplemented bits and unmapped addresses return zero
    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_MASK: begin
                prdata[N_SRC-1:0] = mask;
            end
            ADDR_PRIO: begin
                prdata[N_SRC*PRIO_W-1:0] = priority_config;
            end
            ADDR_MODE: begin
                prdata[N_SRC-1:0] = edge_mode;
            end
            ADDR_PENDING: begin
                prdata[N_SRC-1:0] = pending;
            end
            ADDR_CLAIM: begin
                prdata = claim_word;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/irq_capture.sv
// Source synchronizer and pending capture
`timescale 1ns/1ps
`default_nettype none

module irq_capture
    import intc_pkg::*;
(
    input  wire logic             clock,
    input  wire logic             resetn,
    input  wire logic [N_SRC-1:0] sources,
    input  wire logic [N_SRC-1:0] edge_mode,
    input  wire logic [N_SRC-1:0] clear_pending,
    output logic      [N_SRC-1:0] pending
);

    // Synchronizer chain, stage 0 faces the asynchronous inputs
    logic [N_SRC-1:0] sync_q [SYNC_STAGES];
    logic [N_SRC-1:0] sync_out;
    logic [N_SRC-1:0] sync_prev;
    logic [N_SRC-1:0] rise;

    assign sync_out = sync_q[SYNC_STAGES-1];

    // Rising edge seen on the synchronized side only
    assign rise = sync_out & ~sync_prev;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            sync_prev <= '0;
        end else begin
            sync_q[0] <= sources;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            sync_prev <= sync_out;
        end
    end

    // Pending bits
    // Level sources mirror the input, edge sources latch until cleared
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            pending <= '0;
        end else begin
            for (int k = 0; k < N_SRC; k++) begin
                if (edge_mode[k]) begin
                    // A new edge in the clear cycle keeps the bit set
                    pending[k] <= (pending[k] && !clear_pending[k]) || rise[k];
                end else begin
                    pending[k] <= sync_out[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/priority_resolver.sv
// Pipelined priority resolver
`timescale 1ns/1ps
`default_nettype none

module priority_resolver
    import intc_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    resetn,
    input  wire logic [N_SRC-1:0]        pending,
    input  wire logic [N_SRC-1:0]        mask,
    input  wire logic [N_SRC*PRIO_W-1:0] priority_config,
    output logic                         irq,
    output logic      [ID_W-1:0]         irq_id
);

    localparam int HALF = N_SRC / 2;

    // Stage 1 registers
    logic [N_SRC-1:0]  req_q;
    logic [PRIO_W-1:0] prio_q [N_SRC];

    // Per-half search results, index 0 is sources 0-3
    logic              half_found [2];
    logic [PRIO_W-1:0] half_prio [2];
    logic [ID_W-1:0]   half_idx [2];

    // Stage 2 registers
    logic              s2_found [2];
    logic [PRIO_W-1:0] s2_prio [2];
    logic [ID_W-1:0]   s2_idx [2];

    // Stage 1, qualified requests
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            req_q <= '0;
        end else begin
            req_q <= pending & ~mask;
        end
    end

    // Stage 1, unpacked priorities
    always_ff @(posedge clock) begin
        for (int k = 0; k < N_SRC; k++) begin
            prio_q[k] <= priority_config[k*PRIO_W +: PRIO_W];
        end
    end

    // Winner of each half
    // Scanning upward with a strict compare keeps the lower index on ties;
    // the first request found is taken even at priority 0
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            half_found[h] = 1'b0;
            half_prio[h] = '0;
            half_idx[h] = '0;
            for (int k = h * HALF; k < (h + 1) * HALF; k++) begin
                if (req_q[k] && (!half_found[h] || (prio_q[k] > half_prio[h]))) begin
                    half_found[h] = 1'b1;
                    half_prio[h] = prio_q[k];
                    half_idx[h] = ID_W'(k);
                end
            end
        end
    end

    // Stage 2, found flags
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            s2_found[0] <= 1'b0;
            s2_found[1] <= 1'b0;
        end else begin
            s2_found[0] <= half_found[0];
            s2_found[1] <= half_found[1];
        end
    end

    // Stage 2, winner payload
    always_ff @(posedge clock) begin
        for (int h = 0; h < 2; h++) begin
            s2_prio[h] <= half_prio[h];
            s2_idx[h] <= half_idx[h];
        end
    end

    // Stage 3, final merge
    // Upper half needs a strictly higher priority to win
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            irq <= 1'b0;
            irq_id <= '0;
        end else begin
            irq <= s2_found[0] || s2_found[1];
            if (s2_found[1] && (!s2_found[0] || (s2_prio[1] > s2_prio[0]))) begin
                irq_id <= s2_idx[1];
            end else if (s2_found[0]) begin
                irq_id <= s2_idx[0];
            end else begin
                irq_id <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/intc_top.sv
// Interrupt controller top level
`timescale 1ns/1ps
`default_nettype none

module intc_top
    import intc_pkg::*;
(
    input  wire logic             clock,
    input  wire logic             resetn,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire logic [7:0]       paddr,
    input  wire logic [31:0]      pwdata,
    output wire logic [31:0]      prdata,
    input  wire logic [N_SRC-1:0] sources,
    output wire logic             irq,
    output wire logic [ID_W-1:0]  irq_id
);

    wire logic [N_SRC-1:0]        mask;
    wire logic [N_SRC*PRIO_W-1:0] priority_config;
    wire logic [N_SRC-1:0]        edge_mode;
    wire logic [N_SRC-1:0]        clear_pending;
    wire logic [N_SRC-1:0]        pending;

    intc_regs u_regs (
        .clock           (clock),
        .resetn          (resetn),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pending         (pending),
        .irq             (irq),
        .irq_id          (irq_id),
        .mask            (mask),
        .priority_config (priority_config),
        .edge_mode       (edge_mode),
        .clear_pending   (clear_pending)
    );

    irq_capture u_capture (
        .clock         (clock),
        .resetn        (resetn),
        .sources       (sources),
        .edge_mode     (edge_mode),
        .clear_pending (clear_pending),
        .pending       (pending)
    );

    priority_resolver u_resolver (
        .clock           (clock),
        .resetn          (resetn),
        .pending         (pending),
        .mask            (mask),
        .priority_config (priority_config),
        .irq             (irq),
        .irq_id          (irq_id)
    );

endmodule

`default_nettype wire

// File: bench/intc_asserts.sv
// Interrupt controller assertions
`timescale 1ns/1ps
`default_nettype none

module intc_asserts
    import intc_pkg::*;
(
    input wire logic             clock,
    input wire logic             resetn,
    input wire logic [N_SRC-1:0] pending,
    input wire logic [N_SRC-1:0] mask,
    input wire logic             irq,
    input wire logic [ID_W-1:0]  irq_id
);

    logic [N_SRC-1:0] qualified;

    // Requests as the resolver registers them in its first stage
    assign qualified = pending & ~mask;

    irq_low_in_reset: assert property (@(posedge clock) !resetn |-> !irq)
        else $error("irq is high while resetn is low");

    id_zero_when_idle: assert property (
        @(posedge clock) disable iff (!resetn) !irq |-> (irq_id == '0)
    ) else $error("irq_id is nonzero while irq is low");

    // Winner must have been a live request when it entered the pipeline
    id_was_requested: assert property (
        @(posedge clock) disable iff (!resetn)
        irq |-> ((($past(qualified, 3) >> irq_id) & N_SRC'(1)) != '0)
    ) else $error("irq_id %0d was not a pending unmasked source", irq_id);

endmodule

bind intc_top intc_asserts u_asserts (
    .clock   (clock),
    .resetn  (resetn),
    .pending (pending),
    .mask    (mask),
    .irq     (irq),
    .irq_id  (irq_id)
);

`default_nettype wire

// File: bench/intc_tb.sv
// Interrupt controller testbench
`timescale 1ns/1ps
`default_nettype none

module intc_tb
    import intc_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SRC_LATENCY = 6;
    localparam int REG_LATENCY = 3;
    localparam int RAND_ITERS = 200;
    localparam int TIE_ITERS = 16;
    // Random iterations take about 16 cycles each and directed tests stay under 800
    localparam int TIMEOUT_CYCLES = RAND_ITERS * 16 + 800;

    logic                    clock;
    logic                    resetn;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [7:0]              paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic [N_SRC-1:0]        sources;
    logic                    irq;
    logic [ID_W-1:0]         irq_id;

    // Bench copies of the configuration and pending state
    logic [N_SRC-1:0]        src_model;
    logic [N_SRC-1:0]        pend_model;
    logic [N_SRC-1:0]        mask_model;
    logic [N_SRC-1:0]        mode_model;
    logic [N_SRC*PRIO_W-1:0] prio_model;
    logic                    exp_irq;
    logic [ID_W-1:0]         exp_id;
    logic [31:0]             rng_state;
    int                      check_delay;
    int                      error_count;
    int                      check_count;
    int                      test_count;
    int                      test_first_error;
    int                      cycle_count = 0;
    event                    check_req;
    event                    check_done;

    intc_top u_dut (
        .clock   (clock),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .sources (sources),
        .irq     (irq),
        .irq_id  (irq_id)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [N_SRC-1:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[16 +: N_SRC];
    endfunction

    // Highest priority value among unmasked pending sources, lowest index on a tie
    function automatic logic [ID_W:0] expected_claim(
        input logic [N_SRC-1:0]        pend,
        input logic [N_SRC-1:0]        msk,
        input logic [N_SRC*PRIO_W-1:0] prio
    );
        logic              found;
        logic [PRIO_W-1:0] best;
        logic [ID_W-1:0]   id;
        found = 1'b0;
        best = '0;
        id = '0;
        for (int k = 0; k < N_SRC; k++) begin
            if (pend[k] && !msk[k] && (!found || prio[k*PRIO_W +: PRIO_W] > best)) begin
                found = 1'b1;
                best = prio[k*PRIO_W +: PRIO_W];
                id = ID_W'(k);
            end
        end
        return {found, id};
    endfunction

    // CLAIM word holds valid in bit 8 and the id in the low bits
    function automatic logic [31:0] claim_value(input logic valid, input logic [ID_W-1:0] id);
        logic [31:0] w;
        w = '0;
        w[8] = valid;
        w[ID_W-1:0] = id;
        return w;
    endfunction

    task automatic check_irq(input logic actual, input logic expected, input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_id(input logic [ID_W-1:0] actual, input logic [ID_W-1:0] expected,
                            input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    // Compare process samples irq and irq_id once the pipeline has settled
    initial begin
        forever begin
            @(check_req);
            repeat (check_delay) @(posedge clock);
            @(negedge clock);
            check_irq(irq, exp_irq, "irq");
            check_id(irq_id, exp_id, "irq_id");
            -> check_done;
        end
    end

    task automatic await_outputs(input int edges);
        logic [ID_W:0] claim;
        claim = expected_claim(pend_model, mask_model, prio_model);
        exp_irq = claim[ID_W];
        exp_id = claim[ID_W-1:0];
        check_delay = edges;
        -> check_req;
        @(check_done);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        case (addr)
            ADDR_MASK: mask_model = data[N_SRC-1:0];
            ADDR_PRIO: prio_model = data[N_SRC*PRIO_W-1:0];
            ADDR_MODE: begin
                mode_model = data[N_SRC-1:0];
                pend_model = (pend_model & mode_model) | (src_model & ~mode_model);
            end
            ADDR_PENDING: pend_model = pend_model & ~(data[N_SRC-1:0] & mode_model);
            default: begin
            end
        endcase
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        data = prdata;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic verify_register(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        apb_read(addr, data);
        check_word(data, expected, "prdata");
    endtask

    task automatic drive_sources(input logic [N_SRC-1:0] value);
        @(posedge clock);
        sources <= value;
        // Level bits follow the input and edge bits latch a rising input
        pend_model = ((pend_model | (value & ~src_model)) & mode_model) | (value & ~mode_model);
        src_model = value;
    endtask

    task automatic mark_test_start();
        test_first_error = error_count;
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == test_first_error) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, error_count - test_first_error);
        end
    endtask

    initial begin
        logic [31:0]             word;
        logic [N_SRC*PRIO_W-1:0] tie_prio;
        logic [N_SRC-1:0]        subset;
        rng_state = 32'd65787;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        src_model = '0;
        pend_model = '0;
        mask_model = '1;
        mode_model = '0;
        prio_model = '0;
        resetn <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        sources <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        resetn <= 1'b1;

        mark_test_start();
        verify_register(ADDR_MASK, 32'h0000_00FF);
        verify_register(ADDR_PRIO, 32'h0);
        verify_register(ADDR_MODE, 32'h0);
        verify_register(ADDR_PENDING, 32'h0);
        verify_register(ADDR_CLAIM, 32'h0);
        @(negedge clock);
        check_irq(irq, 1'b0, "irq");
        report_test("reset_values");

        mark_test_start();
        word = rand_word();
        apb_write(ADDR_MASK, word);
        verify_register(ADDR_MASK, word & 32'h0000_00FF);
        word = rand_word();
        apb_write(ADDR_PRIO, word);
        verify_register(ADDR_PRIO, word & 32'h00FF_FFFF);
        word = rand_word();
        apb_write(ADDR_MODE, word);
        verify_register(ADDR_MODE, word & 32'h0000_00FF);
        report_test("register_readback");

        mark_test_start();
        apb_write(ADDR_MODE, 32'h0);
        for (int i = 0; i < RAND_ITERS; i++) begin
            apb_write(ADDR_PRIO, rand_word());
            apb_write(ADDR_MASK, 32'(rand_byte()));
            drive_sources(rand_byte());
            await_outputs(SRC_LATENCY);
            verify_register(ADDR_CLAIM, claim_value(exp_irq, exp_id));
        end
        report_test("level_arbitration");

        mark_test_start();
        for (int k = 0; k < N_SRC; k++) begin
            tie_prio[k*PRIO_W +: PRIO_W] = PRIO_W'(5);
        end
        apb_write(ADDR_PRIO, 32'(tie_prio));
        apb_write(ADDR_MASK, 32'h0);
        for (int i = 0; i < TIE_ITERS; i++) begin
            case (i)
                0: subset = 8'h90;
                1: subset = 8'h18;
                2: subset = 8'hA1;
                default: subset = rand_byte();
            endcase
            drive_sources(subset);
            await_outputs(SRC_LATENCY);
        end
        report_test("tie_breaking");

        mark_test_start();
        drive_sources('0);
        await_outputs(SRC_LATENCY);
        apb_write(ADDR_MODE, 32'h0000_00FF);
        // Source 2 at priority 3 and source 5 at priority 6
        apb_write(ADDR_PRIO, 32'h0003_00C0);
        drive_sources(8'h24);
        drive_sources(8'h00);
        await_outputs(SRC_LATENCY);
        verify_register(ADDR_PENDING, 32'h0000_0024);
        apb_write(ADDR_PENDING, 32'h0000_0020);
        await_outputs(REG_LATENCY);
        apb_write(ADDR_PENDING, 32'h0000_0004);
        await_outputs(REG_LATENCY);
        verify_register(ADDR_PENDING, 32'h0);
        report_test("edge_latching");

        mark_test_start();
        apb_write(ADDR_MODE, 32'h0);
        apb_write(ADDR_MASK, 32'h0000_00FF);
        drive_sources(8'h5A);
        await_outputs(SRC_LATENCY);
        verify_register(ADDR_CLAIM, 32'h0);
        apb_write(ADDR_MASK, 32'h0000_00F7);
        await_outputs(REG_LATENCY);
        verify_register(ADDR_CLAIM, claim_value(1'b1, 3'd3));
        report_test("masking");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/intc_pkg.sv
source/intc_regs.sv
source/irq_capture.sv
source/priority_resolver.sv
source/intc_top.sv
bench/intc_asserts.sv
bench/intc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the interrupt controller simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module intc_tb -f filelist.f -o intc_sim &&
./obj_dir/intc_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation did not pass"; exit 1; }
